// ==== files.f ====
common/bomber_av_pkg.sv
src/host_registers.sv
video/raster_timing.sv
audio/sample_timer.sv
audio/sound_arbiter.sv
audio/sample_player.sv
src/bomber_av_top.sv
test/bomber_av_assertions.sv
test/tb_bomber_av.sv

// ==== test/tb_bomber_av.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bomber_av;

    localparam int SAMPLE_DIVIDE = 7;
    localparam int SOUND_SAMPLES = 6;
    localparam int PERIOD = 100;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_ROWS = 17;
    localparam int FIELD = bomber_av_pkg::H_TOTAL * bomber_av_pkg::V_TOTAL;

    // ready patterns of a table row
    localparam logic [1:0] RDY_HIGH = 2'd0;
    localparam logic [1:0] RDY_GAPS = 2'd1;
    localparam logic [1:0] RDY_LOW = 2'd2;

    typedef struct packed {
        bomber_av_pkg::host_write_t host;
        logic [1:0]                 ready_mode;
        logic [15:0]                cycles;
        logic [3:0]                 starts;
    } row_t;

    logic                               clk = 1'b0;
    logic                               reset;
    bomber_av_pkg::host_write_t         host;
    logic                               l_ready;
    logic                               r_ready;
    logic [bomber_av_pkg::SAMPLE_W-1:0] sample_data;
    bomber_av_pkg::sample_req_t         sample_req;
    bomber_av_pkg::audio_out_t          audio;
    bomber_av_pkg::raster_sync_t        sync;

    row_t   rows [NUM_ROWS];
    int     table_cycles = 0;
    integer seed = 37082;

    // reference model state
    // m_state 0 is idle and 1 to 4 follow the priority order
    int                           m_count;
    int                           m_state;
    logic [3:0]                   m_armed;
    int                           m_addr;
    int                           m_h;
    int                           m_v;
    int                           m_cycle;
    bomber_av_pkg::player_state_t m_p1;
    bomber_av_pkg::player_state_t m_p2;
    bomber_av_pkg::audio_out_t    m_audio;
    int                           hs_low_cycles = 0;
    int                           vs_low_cycles = 0;
    int                           blank_cycles = 0;

    bomber_av_top #(
        .SAMPLE_DIVIDE (SAMPLE_DIVIDE),
        .SOUND_SAMPLES (SOUND_SAMPLES)
    ) bomber_av_top_inst (
        .clk         (clk),
        .reset       (reset),
        .host        (host),
        .l_ready     (l_ready),
        .r_ready     (r_ready),
        .sample_data (sample_data),
        .sample_req  (sample_req),
        .audio       (audio),
        .sync        (sync)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] rom_word(input bomber_av_pkg::sound_t sound,
                                             input int address);
        return 16'(sound) * 16'd4096 + 16'(address) + 16'd1;
    endfunction

    // external sample rom answers one clock after the request
    always @(posedge clk) begin
        sample_data <= rom_word(sample_req.sound, sample_req.address);
    end

    function automatic bomber_av_pkg::sound_t state_sound(input int state);
        if (state == 1 || state == 2) return bomber_av_pkg::SOUND_EXPLODE;
        if (state == 3 || state == 4) return bomber_av_pkg::SOUND_JINGLE;
        return bomber_av_pkg::SOUND_NONE;
    endfunction

    function automatic bomber_av_pkg::sample_req_t expected_request(input int state,
                                                                     input int address);
        bomber_av_pkg::sample_req_t r;
        r.sound = state_sound(state);
        r.address = address[bomber_av_pkg::SAMPLE_ADDR_W-1:0];
        return r;
    endfunction

    function automatic bomber_av_pkg::raster_sync_t expected_sync(input int h, input int v);
        bomber_av_pkg::raster_sync_t s;
        int hs_first;
        int vs_first;
        hs_first = bomber_av_pkg::H_ACTIVE + bomber_av_pkg::H_FRONT;
        vs_first = bomber_av_pkg::V_ACTIVE + bomber_av_pkg::V_FRONT;
        s.pix_clk = h[0];
        s.hsync = !(h >= hs_first && h < hs_first + bomber_av_pkg::H_SYNC);
        s.vsync = !(v >= vs_first && v < vs_first + bomber_av_pkg::V_SYNC);
        s.blank_n = h < bomber_av_pkg::H_ACTIVE && v < bomber_av_pkg::V_ACTIVE;
        return s;
    endfunction

    task stop_on_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task check_audio(input bomber_av_pkg::audio_out_t got,
                     input bomber_av_pkg::audio_out_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("audio %h/%h valid %b, expected %h/%h valid %b",
                                    got.left, got.right, got.valid,
                                    exp.left, exp.right, exp.valid));
        end
    endtask

    task check_request(input bomber_av_pkg::sample_req_t got,
                       input bomber_av_pkg::sample_req_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("sample request %0d @ %0d, expected %0d @ %0d",
                                    got.sound, got.address, exp.sound, exp.address));
        end
    endtask

    task check_sync(input bomber_av_pkg::raster_sync_t got,
                    input bomber_av_pkg::raster_sync_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("sync %b at line %0d count %0d, expected %b",
                                    got, m_v, m_h, exp));
        end
    endtask

    task check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_on_error($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task reset_model();
        m_count = 0;
        m_state = 0;
        m_armed = '1;
        m_addr = 0;
        m_h = 0;
        m_v = 0;
        m_cycle = 0;
        m_p1 = '0;
        m_p2 = '0;
        m_audio = '0;
    endtask

    task step_model();
        logic       tick;
        logic       done;
        logic [3:0] on;
        int         e;
        tick = l_ready && r_ready && m_count == SAMPLE_DIVIDE;
        done = 1'b0;
        m_audio.valid = tick;
        if (tick && m_state != 0) begin
            m_audio.left = rom_word(state_sound(m_state), m_addr);
            m_audio.right = m_audio.left;
            done = m_addr == SOUND_SAMPLES - 1;
            m_addr = done ? 0 : m_addr + 1;
        end
        if (tick) begin
            // events listed in priority order
            on = {m_p2.bomb_on, m_p1.bomb_on, m_p2.fire_center, m_p1.fire_center};
            if (m_state == 0) begin
                for (e = 0; e < 4; e++) begin
                    if (m_state == 0 && on[e] && m_armed[e]) begin
                        m_state = e + 1;
                        m_armed[e] = 1'b0;
                    end
                end
            end else if (done) begin
                m_state = 0;
            end
            m_armed = m_armed | ~on;
        end
        m_count = tick ? 0 : m_count + (l_ready && r_ready);
        if (host.chipselect && host.write && host.address == bomber_av_pkg::P1_STATE_ADDR)
            m_p1 = bomber_av_pkg::player_state_t'(host.writedata);
        if (host.chipselect && host.write && host.address == bomber_av_pkg::P2_STATE_ADDR)
            m_p2 = bomber_av_pkg::player_state_t'(host.writedata);
        m_cycle++;
        if (m_h == bomber_av_pkg::H_TOTAL - 1) begin
            m_h = 0;
            m_v = (m_v == bomber_av_pkg::V_TOTAL - 1) ? 0 : m_v + 1;
        end else begin
            m_h++;
        end
    endtask

    always @(posedge clk or posedge reset) begin
        if (reset)
            reset_model();
        else
            step_model();
    end

    always @(negedge clk) begin
        if (!reset) begin
            check_audio(audio, m_audio);
            check_request(sample_req, expected_request(m_state, m_addr));
            check_sync(sync, expected_sync(m_h, m_v));
            if (m_cycle < FIELD) begin
                hs_low_cycles += !sync.hsync;
                vs_low_cycles += !sync.vsync;
                blank_cycles += sync.blank_n;
            end
            if (m_cycle == FIELD - 1) begin
                check_count(hs_low_cycles, bomber_av_pkg::H_SYNC * bomber_av_pkg::V_TOTAL,
                            "hsync low cycles in a field");
                check_count(vs_low_cycles, bomber_av_pkg::V_SYNC * bomber_av_pkg::H_TOTAL,
                            "vsync low cycles in a field");
                check_count(blank_cycles, bomber_av_pkg::H_ACTIVE * bomber_av_pkg::V_ACTIVE,
                            "visible cycles in a field");
            end
        end
    end

    always @(bomber_av_top_inst.av_assertions_inst.failures) begin
        if (bomber_av_top_inst.av_assertions_inst.failures != 0) begin
            $display("A bound assertion failed during the run");
            $display("Checks failed");
            $fatal(1);
        end
    end

    function automatic row_t make_row(input logic cs, input logic we, input logic [4:0] address,
                                      input logic [31:0] data, input logic [1:0] mode,
                                      input int cycles, input int starts);
        row_t r;
        r.host.chipselect = cs;
        r.host.write = we;
        r.host.address = address;
        r.host.writedata = data;
        r.ready_mode = mode;
        r.cycles = 16'(cycles);
        r.starts = 4'(starts);
        return r;
    endfunction

    // 0x10 is fire_center and 0x8 is bomb_on
    // last column counts the sounds started in the row
    task load_table();
        int r;
        rows[0] = make_row(1'b0, 1'b0, 5'd0, 32'h00, RDY_HIGH, 40, 0);
        rows[1] = make_row(1'b0, 1'b0, 5'd0, 32'h00, RDY_GAPS, 120, 0);
        rows[2] = make_row(1'b1, 1'b1, 5'd2, 32'h10, RDY_HIGH, 80, 1);
        rows[3] = make_row(1'b0, 1'b0, 5'd0, 32'h00, RDY_HIGH, 30, 0);
        rows[4] = make_row(1'b1, 1'b1, 5'd2, 32'h00, RDY_HIGH, 20, 0);
        rows[5] = make_row(1'b1, 1'b1, 5'd2, 32'h08, RDY_LOW, 1, 0);
        rows[6] = make_row(1'b1, 1'b1, 5'd10, 32'h10, RDY_LOW, 2, 0);
        rows[7] = make_row(1'b0, 1'b0, 5'd0, 32'h00, RDY_HIGH, 160, 2);
        rows[8] = make_row(1'b1, 1'b1, 5'd10, 32'h00, RDY_HIGH, 20, 0);
        rows[9] = make_row(1'b1, 1'b1, 5'd10, 32'h10, RDY_HIGH, 70, 1);
        rows[10] = make_row(1'b1, 1'b1, 5'd2, 32'h00, RDY_HIGH, 1, 0);
        rows[11] = make_row(1'b1, 1'b1, 5'd10, 32'h00, RDY_HIGH, 30, 0);
        rows[12] = make_row(1'b1, 1'b1, 5'd3, 32'h18, RDY_HIGH, 1, 0);
        rows[13] = make_row(1'b0, 1'b1, 5'd2, 32'h18, RDY_HIGH, 1, 0);
        rows[14] = make_row(1'b1, 1'b0, 5'd10, 32'h18, RDY_HIGH, 1, 0);
        rows[15] = make_row(1'b0, 1'b0, 5'd0, 32'h00, RDY_GAPS, 60, 0);
        rows[16] = make_row(1'b1, 1'b1, 5'd2, 32'h08, RDY_GAPS, 150, 1);
        for (r = 0; r < NUM_ROWS; r++)
            table_cycles += rows[r].cycles;
    endtask

    task drive_ready(input logic [1:0] mode);
        int pick;
        pick = $random(seed) & 7;
        l_ready <= !(mode == RDY_LOW || (mode == RDY_GAPS && (pick == 0 || pick == 2)));
        r_ready <= !(mode == RDY_LOW || (mode == RDY_GAPS && (pick == 1 || pick == 2)));
    endtask

    initial begin
        bomber_av_pkg::sound_t prev_sound;
        int starts;
        int cycles_run;
        int r;
        int c;
        reset = 1'b1;
        host = '0;
        l_ready = 1'b1;
        r_ready = 1'b1;
        sample_data = '0;
        prev_sound = bomber_av_pkg::SOUND_NONE;
        cycles_run = 0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (r = 0; r < NUM_ROWS; r++) begin
            starts = 0;
            for (c = 0; c < rows[r].cycles; c++) begin
                @(posedge clk);
                cycles_run++;
                if (c == 0)
                    host <= rows[r].host;
                else
                    host <= '0;
                drive_ready(rows[r].ready_mode);
                @(negedge clk);
                if (prev_sound == bomber_av_pkg::SOUND_NONE &&
                    sample_req.sound != bomber_av_pkg::SOUND_NONE)
                    starts++;
                prev_sound = sample_req.sound;
            end
            check_count(starts, rows[r].starts, $sformatf("sounds started in row %0d", r));
        end
        // keep going past one full field for the raster counts
        while (cycles_run < FIELD + 2 * bomber_av_pkg::H_TOTAL) begin
            @(posedge clk);
            cycles_run++;
            host <= '0;
            drive_ready(RDY_GAPS);
        end
        @(negedge clk);
        $display("All checks passed");
        $finish;
    end

    initial begin
        wait (table_cycles > 0);
        #((RESET_CYCLES + table_cycles + 2 * FIELD) * PERIOD);
        $display("Timeout: the run did not end within the expected number of clock cycles");
        $display("Checks failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== test/bomber_av_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module bomber_av_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  sample_tick,
    input logic                  l_ready,
    input logic                  r_ready,
    input bomber_av_pkg::sound_t current_sound
);

    int   failures = 0;
    logic tick_seen;

    // first tick since reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_seen <= 1'b0;
        end else if (sample_tick) begin
            tick_seen <= 1'b1;
        end
    end

    sound_changes_on_tick: assert property (
        @(posedge clk) disable iff (reset)
        current_sound != $past(current_sound) |-> $past(sample_tick)
    ) else begin
        $error("current_sound changed outside a tick cycle");
        failures = failures + 1;
    end

    tick_needs_ready: assert property (
        @(posedge clk) disable iff (reset)
        sample_tick |-> l_ready && r_ready
    ) else begin
        $error("sample_tick while an audio channel was not ready");
        failures = failures + 1;
    end

    silent_until_tick: assert property (
        @(posedge clk) disable iff (reset)
        !tick_seen |-> current_sound == bomber_av_pkg::SOUND_NONE
    ) else begin
        $error("a sound started before the first tick after reset");
        failures = failures + 1;
    end

endmodule

bind bomber_av_top bomber_av_assertions av_assertions_inst (
    .clk           (clk),
    .reset         (reset),
    .sample_tick   (sample_tick),
    .l_ready       (l_ready),
    .r_ready       (r_ready),
    .current_sound (current_sound)
);

`default_nettype wire

// ==== src/bomber_av_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bomber_av_top #(
    parameter int SAMPLE_DIVIDE = 3125,
    parameter int SOUND_SAMPLES = 15002
) (
    input  logic                               clk,
    input  logic                               reset,
    input  bomber_av_pkg::host_write_t         host,
    input  logic                               l_ready,
    input  logic                               r_ready,
    input  logic [bomber_av_pkg::SAMPLE_W-1:0] sample_data,
    output bomber_av_pkg::sample_req_t         sample_req,
    output bomber_av_pkg::audio_out_t          audio,
    output bomber_av_pkg::raster_sync_t        sync
);

    bomber_av_pkg::player_state_t p1_state;
    bomber_av_pkg::player_state_t p2_state;
    bomber_av_pkg::sound_t        current_sound;
    logic                         sample_tick;
    logic                         sound_done;

    host_registers host_registers_inst (
        .clk      (clk),
        .reset    (reset),
        .host     (host),
        .p1_state (p1_state),
        .p2_state (p2_state)
    );

    raster_timing raster_timing_inst (
        .clk   (clk),
        .reset (reset),
        .sync  (sync)
    );

    sample_timer #(
        .SAMPLE_DIVIDE (SAMPLE_DIVIDE)
    ) sample_timer_inst (
        .clk         (clk),
        .reset       (reset),
        .l_ready     (l_ready),
        .r_ready     (r_ready),
        .sample_tick (sample_tick)
    );

    sound_arbiter sound_arbiter_inst (
        .clk           (clk),
        .reset         (reset),
        .sample_tick   (sample_tick),
        .p1_state      (p1_state),
        .p2_state      (p2_state),
        .sound_done    (sound_done),
        .current_sound (current_sound)
    );

    sample_player #(
        .SOUND_SAMPLES (SOUND_SAMPLES)
    ) sample_player_inst (
        .clk           (clk),
        .reset         (reset),
        .sample_tick   (sample_tick),
        .current_sound (current_sound),
        .sample_data   (sample_data),
        .sample_req    (sample_req),
        .sound_done    (sound_done),
        .audio         (audio)
    );

endmodule

`default_nettype wire

// ==== audio/sample_player.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_player #(
    parameter int SOUND_SAMPLES = 15002
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                sample_tick,
    input  bomber_av_pkg::sound_t               current_sound,
    input  logic [bomber_av_pkg::SAMPLE_W-1:0]  sample_data,
    output bomber_av_pkg::sample_req_t          sample_req,
    output logic                                sound_done,
    output bomber_av_pkg::audio_out_t           audio
);

    localparam int ADDR_W = bomber_av_pkg::SAMPLE_ADDR_W;
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(SOUND_SAMPLES - 1);

    logic [ADDR_W-1:0] address;
    logic              playing;
    logic              last_sample;

    assign playing = current_sound != bomber_av_pkg::SOUND_NONE;
    assign last_sample = address == LAST_ADDR;
    assign sound_done = sample_tick && playing && last_sample;

    // rom sees the request a full tick period before the data is taken
    always_comb begin
        sample_req.sound = current_sound;
        sample_req.address = address;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            address <= '0;
        end else if (sample_tick && playing) begin
            if (last_sample) begin
                address <= '0;
            end else begin
                address <= address + 1'b1;
            end
        end
    end

    // samples hold between sounds and valid trails the tick by one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            audio <= '0;
        end else begin
            audio.valid <= sample_tick;
            if (sample_tick && playing) begin
                audio.left <= sample_data;
                audio.right <= sample_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== audio/sound_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sound_arbiter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         sample_tick,
    input  bomber_av_pkg::player_state_t p1_state,
    input  bomber_av_pkg::player_state_t p2_state,
    input  logic                         sound_done,
    output bomber_av_pkg::sound_t        current_sound
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_P1_EXPLODE,
        ST_P2_EXPLODE,
        ST_P1_JINGLE,
        ST_P2_JINGLE
    } state_t;

    state_t     state;
    state_t     state_next;
    logic [3:0] event_on;
    logic [3:0] armed;
    logic [3:0] armed_next;
    logic [3:0] pending;

    // bit order is the priority order
    assign event_on = {p2_state.bomb_on, p1_state.bomb_on,
                       p2_state.fire_center, p1_state.fire_center};
    assign pending = event_on & armed;

    always_comb begin
        state_next = state;
        // an event re-arms once its flag has dropped
        armed_next = armed | ~event_on;
        if (state == ST_IDLE) begin
            if (pending[0]) begin
                state_next = ST_P1_EXPLODE;
                armed_next[0] = 1'b0;
            end else if (pending[1]) begin
                state_next = ST_P2_EXPLODE;
                armed_next[1] = 1'b0;
            end else if (pending[2]) begin
                state_next = ST_P1_JINGLE;
                armed_next[2] = 1'b0;
            end else if (pending[3]) begin
                state_next = ST_P2_JINGLE;
                armed_next[3] = 1'b0;
            end
        end else if (sound_done) begin
            // nothing new starts on the ending tick
            state_next = ST_IDLE;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            armed <= '1;
        end else if (sample_tick) begin
            state <= state_next;
            armed <= armed_next;
        end
    end

    always_comb begin
        case (state)
            ST_P1_EXPLODE, ST_P2_EXPLODE: current_sound = bomber_av_pkg::SOUND_EXPLODE;
            ST_P1_JINGLE, ST_P2_JINGLE:   current_sound = bomber_av_pkg::SOUND_JINGLE;
            default:                      current_sound = bomber_av_pkg::SOUND_NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== audio/sample_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_timer #(
    parameter int SAMPLE_DIVIDE = 3125
) (
    input  logic clk,
    input  logic reset,
    input  logic l_ready,
    input  logic r_ready,
    output logic sample_tick
);

    localparam int CNT_W = $clog2(SAMPLE_DIVIDE + 1);

    logic [CNT_W-1:0] count;
    logic             both_ready;

    assign both_ready = l_ready && r_ready;

    // one tick every SAMPLE_DIVIDE+1 ready cycles
    assign sample_tick = both_ready && (count == CNT_W'(SAMPLE_DIVIDE));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (sample_tick) begin
            count <= '0;
        end else if (both_ready) begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== video/raster_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_timing (
    input  logic                        clk,
    input  logic                        reset,
    output bomber_av_pkg::raster_sync_t sync
);

    localparam int H_W = $clog2(bomber_av_pkg::H_TOTAL);
    localparam int V_W = $clog2(bomber_av_pkg::V_TOTAL);

    // inclusive sync pulse windows
    localparam int HS_FIRST = bomber_av_pkg::H_ACTIVE + bomber_av_pkg::H_FRONT;
    localparam int HS_LAST = HS_FIRST + bomber_av_pkg::H_SYNC - 1;
    localparam int VS_FIRST = bomber_av_pkg::V_ACTIVE + bomber_av_pkg::V_FRONT;
    localparam int VS_LAST = VS_FIRST + bomber_av_pkg::V_SYNC - 1;

    logic [H_W-1:0] hcount;
    logic [V_W-1:0] vcount;
    logic           end_of_line;
    logic           end_of_field;

    assign end_of_line = hcount == H_W'(bomber_av_pkg::H_TOTAL - 1);
    assign end_of_field = vcount == V_W'(bomber_av_pkg::V_TOTAL - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // field counter steps once per line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vcount <= '0;
        end else if (end_of_line) begin
            if (end_of_field) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    always_comb begin
        // pixel clock is half the system clock
        sync.pix_clk = hcount[0];
        sync.hsync = !(hcount >= HS_FIRST && hcount <= HS_LAST);
        sync.vsync = !(vcount >= VS_FIRST && vcount <= VS_LAST);
        sync.blank_n = (hcount < bomber_av_pkg::H_ACTIVE) &&
                       (vcount < bomber_av_pkg::V_ACTIVE);
    end

endmodule

`default_nettype wire

// ==== src/host_registers.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_registers (
    input  logic                         clk,
    input  logic                         reset,
    input  bomber_av_pkg::host_write_t   host,
    output bomber_av_pkg::player_state_t p1_state,
    output bomber_av_pkg::player_state_t p2_state
);

    logic write_strobe;
    logic p1_hit;
    logic p2_hit;

    assign write_strobe = host.chipselect && host.write;

    // all other addresses are ignored
    assign p1_hit = host.address == bomber_av_pkg::P1_STATE_ADDR;
    assign p2_hit = host.address == bomber_av_pkg::P2_STATE_ADDR;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p1_state <= '0;
        end else if (write_strobe && p1_hit) begin
            p1_state <= bomber_av_pkg::player_state_t'(host.writedata);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p2_state <= '0;
        end else if (write_strobe && p2_hit) begin
            p2_state <= bomber_av_pkg::player_state_t'(host.writedata);
        end
    end

endmodule

`default_nettype wire

// ==== common/bomber_av_pkg.sv ====
`default_nettype none

package bomber_av_pkg;

    // external sample rom
    localparam int SAMPLE_ADDR_W = 14;
    localparam int SAMPLE_W = 16;

    // host register map
    localparam logic [4:0] P1_STATE_ADDR = 5'd2;
    localparam logic [4:0] P2_STATE_ADDR = 5'd10;

    // 640x480 with two clocks per pixel
    localparam int H_ACTIVE = 1280;
    localparam int H_FRONT = 32;
    localparam int H_SYNC = 192;
    localparam int H_BACK = 96;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT = 10;
    localparam int V_SYNC = 2;
    localparam int V_BACK = 33;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    typedef struct packed {
        logic        chipselect;
        logic        write;
        logic [4:0]  address;
        logic [31:0] writedata;
    } host_write_t;

    typedef struct packed {
        logic        start_ready;
        logic [21:0] reserved;
        logic        fire_right;
        logic        fire_left;
        logic        fire_down;
        logic        fire_up;
        logic        fire_center;
        logic        bomb_on;
        logic        alive;
        logic [1:0]  dir;
    } player_state_t;

    typedef enum logic [1:0] {
        SOUND_NONE    = 2'd0,
        SOUND_EXPLODE = 2'd1,
        SOUND_JINGLE  = 2'd2
    } sound_t;

    typedef struct packed {
        sound_t                   sound;
        logic [SAMPLE_ADDR_W-1:0] address;
    } sample_req_t;

    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
        logic                valid;
    } audio_out_t;

    typedef struct packed {
        logic pix_clk;
        logic hsync;
        logic vsync;
        logic blank_n;
    } raster_sync_t;

endpackage

`default_nettype wire
